//--- hdl/sdram_pkg.sv
package sdram_pkg;

   // device geometry, 16-bit part with four banks
   localparam int BA_W      = 2;
   localparam int ROW_W     = 13;
   localparam int COL_W     = 9;
   localparam int DQ_W      = 16;
   localparam int DQM_W     = 2;
   localparam int PORT_ID_W = 2;

   // address bit that requests auto-precharge on READ and WRITE
   localparam int AP_BIT = 10;

   // {ras_n, cas_n, we_n}
   localparam logic [2:0] CMD_NOP          = 3'b111;
   localparam logic [2:0] CMD_ACTIVE       = 3'b011;
   localparam logic [2:0] CMD_READ         = 3'b101;
   localparam logic [2:0] CMD_WRITE        = 3'b100;
   localparam logic [2:0] CMD_AUTO_REFRESH = 3'b001;

   typedef struct packed {
      logic             write;
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] row;
      logic [COL_W-1:0] col;
      logic [DQ_W-1:0]  wdata;
      logic [DQM_W-1:0] be;
   } sdram_req_t;

   typedef struct packed {
      logic [PORT_ID_W-1:0] port_id;
      sdram_req_t           req;
   } sdram_grant_t;

   typedef struct packed {
      logic             cs_n;
      logic             ras_n;
      logic             cas_n;
      logic             we_n;
      logic [BA_W-1:0]  ba;
      logic [ROW_W-1:0] addr;
      logic [DQM_W-1:0] dqm;
      logic             cke;
   } sdram_pins_t;

endpackage

//--- hdl/req_queue.sv
`timescale 1ns/1ps

module req_queue #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                  sdram_clk,
   input  logic                  sdram_rst,
   input  logic                  push_i,
   input  sdram_pkg::sdram_req_t push_data_i,
   output logic                  full_o,
   input  logic                  pop_i,
   output sdram_pkg::sdram_req_t head_o,
   output logic                  empty_o
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   sdram_pkg::sdram_req_t mem [QUEUE_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic                  do_push;
   logic                  do_pop;

   // circular pointer step
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
   assign empty_o = (count == '0);
   // a push into a full queue is lost here
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;
   assign head_o  = mem[rd_ptr];

   always_ff @(posedge sdram_clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hdl/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter #(
   parameter int NUM_PORTS = 4
) (
   input  logic                    sdram_clk,
   input  logic                    sdram_rst,
   input  logic [NUM_PORTS-1:0]    q_empty_i,
   input  sdram_pkg::sdram_req_t   q_head_i [NUM_PORTS],
   output logic [NUM_PORTS-1:0]    q_pop_o,
   output sdram_pkg::sdram_grant_t grant_o,
   output logic                    grant_valid_o,
   input  logic                    grant_take_i
);

   localparam int ID_W = sdram_pkg::PORT_ID_W;

   logic [ID_W-1:0] sel_idx;
   logic            any_ready;
   logic            load;

   // fixed priority, lowest-numbered non-empty queue wins
   always_comb begin
      sel_idx   = '0;
      any_ready = 1'b0;
      for (int p = NUM_PORTS - 1; p >= 0; p--) begin
         if (!q_empty_i[p]) begin
            sel_idx   = ID_W'(p);
            any_ready = 1'b1;
         end
      end
   end

   // refill when the slot is empty or handed over this cycle
   assign load    = any_ready && (!grant_valid_o || grant_take_i);
   assign q_pop_o = load ? (NUM_PORTS'(1) << sel_idx) : '0;

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         grant_valid_o <= 1'b0;
      end else if (load) begin
         grant_valid_o <= 1'b1;
      end else if (grant_take_i) begin
         grant_valid_o <= 1'b0;
      end
   end

   // grant register, stable until taken
   always_ff @(posedge sdram_clk) begin
      if (load) begin
         grant_o.port_id <= sel_idx;
         grant_o.req     <= q_head_i[sel_idx];
      end
   end

endmodule

//--- hdl/sdram_sequencer.sv
`timescale 1ns/1ps

module sdram_sequencer #(
   parameter int T_RCD            = 2,
   parameter int T_RECOVER        = 3,
   parameter int T_RFC            = 7,
   parameter int REFRESH_INTERVAL = 64
) (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  sdram_pkg::sdram_grant_t         grant_i,
   input  logic                            grant_valid_i,
   output logic                            grant_take_o,
   output sdram_pkg::sdram_pins_t          pins_o,
   output logic [sdram_pkg::DQ_W-1:0]      dq_o,
   output logic                            dq_oe_o,
   output logic                            rd_cmd_o,
   output logic [sdram_pkg::PORT_ID_W-1:0] rd_port_o
);

   localparam int REF_W  = $clog2(REFRESH_INTERVAL);
   localparam int WAIT_W = $clog2(T_RCD + T_RECOVER + T_RFC + 1);

   localparam sdram_pkg::sdram_pins_t NOP_PINS = '{
      cs_n: 1'b0, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
      ba: '0, addr: '0, dqm: '0, cke: 1'b1
   };

   typedef enum logic [2:0] {
      IDLE,
      ACTIVE_WAIT,
      ACCESS,
      RECOVER,
      REFRESH_WAIT
   } state_t;

   state_t                      state;
   logic [WAIT_W-1:0]           wait_cnt;
   logic [REF_W-1:0]            ref_cnt;
   logic                        ref_wrap;
   logic                        ref_pending;
   logic                        start_ref;
   sdram_pkg::sdram_grant_t     cur;
   logic [sdram_pkg::ROW_W-1:0] access_addr;

   assign ref_wrap     = (ref_cnt == REF_W'(REFRESH_INTERVAL - 1));
   // a pending refresh beats a waiting grant
   assign start_ref    = (state == IDLE) && ref_pending;
   assign grant_take_o = (state == IDLE) && !ref_pending && grant_valid_i;

   // column in the low bits, A10 high for auto-precharge
   always_comb begin
      access_addr = '0;
      access_addr[sdram_pkg::COL_W-1:0] = cur.req.col;
      access_addr[sdram_pkg::AP_BIT]    = 1'b1;
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         ref_cnt     <= '0;
         ref_pending <= 1'b0;
      end else begin
         ref_cnt <= ref_wrap ? '0 : ref_cnt + 1'b1;
         if (ref_wrap) begin
            ref_pending <= 1'b1;
         end else if (start_ref) begin
            ref_pending <= 1'b0;
         end
      end
   end

   // arbiter reloads on take, so keep our own copy
   always_ff @(posedge sdram_clk) begin
      if (grant_take_o) begin
         cur <= grant_i;
      end
      if (state == ACCESS && cur.req.write) begin
         dq_o <= cur.req.wdata;
      end
   end

   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         state     <= IDLE;
         wait_cnt  <= '0;
         pins_o    <= NOP_PINS;
         dq_oe_o   <= 1'b0;
         rd_cmd_o  <= 1'b0;
         rd_port_o <= '0;
      end else begin
         // NOP unless a state below issues a command
         {pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= sdram_pkg::CMD_NOP;
         pins_o.dqm <= '0;
         dq_oe_o    <= 1'b0;
         rd_cmd_o   <= 1'b0;
         case (state)
            IDLE: begin
               if (start_ref) begin
                  {pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= sdram_pkg::CMD_AUTO_REFRESH;
                  wait_cnt <= WAIT_W'(T_RFC - 1);
                  state    <= REFRESH_WAIT;
               end else if (grant_take_o) begin
                  {pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= sdram_pkg::CMD_ACTIVE;
                  pins_o.ba   <= grant_i.req.ba;
                  pins_o.addr <= grant_i.req.row;
                  wait_cnt    <= WAIT_W'(T_RCD - 2);
                  state       <= (T_RCD > 1) ? ACTIVE_WAIT : ACCESS;
               end
            end
            ACTIVE_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= ACCESS;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            ACCESS: begin
               pins_o.ba   <= cur.req.ba;
               pins_o.addr <= access_addr;
               if (cur.req.write) begin
                  {pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= sdram_pkg::CMD_WRITE;
                  pins_o.dqm <= ~cur.req.be;
                  dq_oe_o    <= 1'b1;
               end else begin
                  {pins_o.ras_n, pins_o.cas_n, pins_o.we_n} <= sdram_pkg::CMD_READ;
                  rd_cmd_o  <= 1'b1;
                  rd_port_o <= cur.port_id;
               end
               wait_cnt <= WAIT_W'(T_RECOVER - 1);
               state    <= RECOVER;
            end
            RECOVER, REFRESH_WAIT: begin
               if (wait_cnt == '0) begin
                  state <= IDLE;
               end else begin
                  wait_cnt <= wait_cnt - 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

//--- hdl/read_capture.sv
`timescale 1ns/1ps

module read_capture #(
   parameter int CAS_LATENCY = 2
) (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  logic                            rd_cmd_i,
   input  logic [sdram_pkg::PORT_ID_W-1:0] rd_port_i,
   input  logic [sdram_pkg::DQ_W-1:0]      dq_i,
   output logic                            rd_valid_o,
   output logic [sdram_pkg::PORT_ID_W-1:0] rd_port_o,
   output logic [sdram_pkg::DQ_W-1:0]      rd_data_o
);

   logic [CAS_LATENCY-1:0]          vld_dly;
   logic [sdram_pkg::PORT_ID_W-1:0] port_dly [CAS_LATENCY];

   // read strobe delayed one stage per cycle of CAS latency
   always_ff @(posedge sdram_clk or posedge sdram_rst) begin
      if (sdram_rst) begin
         vld_dly    <= '0;
         rd_valid_o <= 1'b0;
      end else begin
         vld_dly    <= CAS_LATENCY'({vld_dly, rd_cmd_i});
         rd_valid_o <= vld_dly[CAS_LATENCY-1];
      end
   end

   // port tag follows the strobe; data register lines up with the last stage
   always_ff @(posedge sdram_clk) begin
      port_dly[0] <= rd_port_i;
      for (int i = 1; i < CAS_LATENCY; i++) begin
         port_dly[i] <= port_dly[i-1];
      end
      rd_port_o <= port_dly[CAS_LATENCY-1];
      rd_data_o <= dq_i;
   end

endmodule

//--- hdl/sdram_ctrl_top.sv
`timescale 1ns/1ps

module sdram_ctrl_top #(
   parameter int NUM_PORTS        = 4,
   parameter int QUEUE_DEPTH      = 4,
   parameter int T_RCD            = 2,
   parameter int T_RECOVER        = 3,
   parameter int T_RFC            = 7,
   parameter int REFRESH_INTERVAL = 64,
   parameter int CAS_LATENCY      = 2
) (
   input  logic                            sdram_clk,
   input  logic                            sdram_rst,
   input  logic [NUM_PORTS-1:0]            req_push_i,
   input  sdram_pkg::sdram_req_t           req_data_i [NUM_PORTS],
   output logic [NUM_PORTS-1:0]            req_full_o,
   output sdram_pkg::sdram_pins_t          sdram_o,
   output logic [sdram_pkg::DQ_W-1:0]      dq_o,
   output logic                            dq_oe_o,
   input  logic [sdram_pkg::DQ_W-1:0]      dq_i,
   output logic                            rd_valid_o,
   output logic [sdram_pkg::PORT_ID_W-1:0] rd_port_o,
   output logic [sdram_pkg::DQ_W-1:0]      rd_data_o
);

   logic [NUM_PORTS-1:0]            q_empty;
   logic [NUM_PORTS-1:0]            q_pop;
   sdram_pkg::sdram_req_t           q_head [NUM_PORTS];
   sdram_pkg::sdram_grant_t         grant;
   logic                            grant_valid;
   logic                            grant_take;
   logic                            rd_cmd;
   logic [sdram_pkg::PORT_ID_W-1:0] rd_cmd_port;

   // one request queue per port
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_queue
      req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
         .sdram_clk   (sdram_clk),
         .sdram_rst   (sdram_rst),
         .push_i      (req_push_i[p]),
         .push_data_i (req_data_i[p]),
         .full_o      (req_full_o[p]),
         .pop_i       (q_pop[p]),
         .head_o      (q_head[p]),
         .empty_o     (q_empty[p])
      );
   end

   port_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arbiter (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .q_empty_i     (q_empty),
      .q_head_i      (q_head),
      .q_pop_o       (q_pop),
      .grant_o       (grant),
      .grant_valid_o (grant_valid),
      .grant_take_i  (grant_take)
   );

   sdram_sequencer #(
      .T_RCD            (T_RCD),
      .T_RECOVER        (T_RECOVER),
      .T_RFC            (T_RFC),
      .REFRESH_INTERVAL (REFRESH_INTERVAL)
   ) u_sequencer (
      .sdram_clk     (sdram_clk),
      .sdram_rst     (sdram_rst),
      .grant_i       (grant),
      .grant_valid_i (grant_valid),
      .grant_take_o  (grant_take),
      .pins_o        (sdram_o),
      .dq_o          (dq_o),
      .dq_oe_o       (dq_oe_o),
      .rd_cmd_o      (rd_cmd),
      .rd_port_o     (rd_cmd_port)
   );

   read_capture #(.CAS_LATENCY(CAS_LATENCY)) u_capture (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .rd_cmd_i   (rd_cmd),
      .rd_port_i  (rd_cmd_port),
      .dq_i       (dq_i),
      .rd_valid_o (rd_valid_o),
      .rd_port_o  (rd_port_o),
      .rd_data_o  (rd_data_o)
   );

endmodule

//--- testbench/sdram_assertions.sv
`timescale 1ns/1ps

module sdram_assertions #(
   parameter int T_RCD = 2,
   parameter int T_RFC = 7
) (
   input logic                   sdram_clk,
   input logic                   sdram_rst,
   input sdram_pkg::sdram_pins_t pins_i,
   input logic                   dq_oe_i
);

   logic [2:0] cmd;
   int         fail_count = 0;

   assign cmd = {pins_i.ras_n, pins_i.cas_n, pins_i.we_n};

   // column command lands T_RCD cycles after the row opens in the same bank
   act_to_access: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      cmd == sdram_pkg::CMD_ACTIVE |-> ##T_RCD
         ((cmd == sdram_pkg::CMD_READ || cmd == sdram_pkg::CMD_WRITE)
          && pins_i.ba == $past(pins_i.ba, T_RCD)))
      else begin
         $error("READ or WRITE missing T_RCD cycles after ACTIVATE to the same bank");
         fail_count++;
      end

   // refresh cycle time holds the bus quiet
   refresh_quiet: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      cmd == sdram_pkg::CMD_AUTO_REFRESH |=> (cmd == sdram_pkg::CMD_NOP) [*T_RFC])
      else begin
         $error("command issued inside T_RFC after AUTO REFRESH");
         fail_count++;
      end

   dq_drive_write: assert property (@(posedge sdram_clk) disable iff (sdram_rst)
      dq_oe_i |-> cmd == sdram_pkg::CMD_WRITE)
      else begin
         $error("dq_oe_o high without a WRITE command");
         fail_count++;
      end

endmodule

bind sdram_sequencer sdram_assertions #(
   .T_RCD (T_RCD),
   .T_RFC (T_RFC)
) u_assertions (
   .sdram_clk (sdram_clk),
   .sdram_rst (sdram_rst),
   .pins_i    (pins_o),
   .dq_oe_i   (dq_oe_o)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int RESET_CYCLES = 3
) (
   output logic sdram_clk_o,
   output logic sdram_rst_o
);

   // 4 ns period
   initial begin
      sdram_clk_o = 1'b0;
      forever #2 sdram_clk_o = ~sdram_clk_o;
   end

   initial begin
      sdram_rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge sdram_clk_o);
      sdram_rst_o <= 1'b0;
   end

endmodule

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
   parameter int NUM_PORTS     = 4,
   parameter int REFRESH_LIMIT = 78
) (
   input  logic                   sdram_clk_i,
   input  logic                   sdram_rst_i,
   input  logic [3:0]             test_id_i,
   input  logic                   test_end_i,
   input  logic                   report_i,
   input  logic [NUM_PORTS-1:0]   req_push_i,
   input  sdram_pkg::sdram_req_t  req_data_i [NUM_PORTS],
   input  logic [NUM_PORTS-1:0]   req_full_i,
   input  sdram_pkg::sdram_pins_t pins_i,
   input  logic                   dq_oe_i,
   input  logic                   rd_valid_i,
   input  logic [1:0]             rd_port_i,
   input  logic [15:0]            rd_data_i,
   output int                     pending_o,
   output int                     errors_o
);

   logic [15:0] ref_mem [logic [23:0]];
   logic [15:0] exp_q [NUM_PORTS][$];
   int          total_errs = 0;
   int          test_errs = 0;
   int          tests_run = 0;
   int          tests_ok = 0;
   int          last_port = -1;
   int          refresh_gap = 0;
   int          refresh_seen = 0;
   logic        gap_flagged = 1'b0;
   logic        full_seen = 1'b0;

   assign errors_o = total_errs;

   // byte-masked merge of a write into the stored word
   function automatic logic [15:0] merge_bytes(input logic [15:0] old_word,
                                               input logic [15:0] new_word,
                                               input logic [1:0]  be);
      logic [15:0] w;
      w = old_word;
      for (int b = 0; b < 2; b++) begin
         if (be[b]) begin
            w[b*8 +: 8] = new_word[b*8 +: 8];
         end
      end
      return w;
   endfunction

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'd1:    return "reset_state";
         4'd2:    return "write_read";
         4'd3:    return "byte_mask";
         4'd4:    return "port_priority";
         4'd5:    return "queue_full";
         4'd6:    return "refresh_run";
         default: return "idle";
      endcase
   endfunction

   task automatic note_error();
      test_errs++;
      total_errs++;
   endtask

   initial pending_o = 0;

   always @(posedge sdram_clk_i) begin
      int          inc;
      int          dec;
      logic [2:0]  cmd;
      logic [23:0] key;
      logic [15:0] old_word;
      logic [15:0] exp_word;
      inc = 0;
      dec = 0;
      cmd = {pins_i.ras_n, pins_i.cas_n, pins_i.we_n};
      if (!sdram_rst_i) begin
         // accepted pushes update the reference in push order
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_push_i[p] && !req_full_i[p]) begin
               inc++;
               key = {req_data_i[p].ba, req_data_i[p].row, req_data_i[p].col};
               old_word = ref_mem.exists(key) ? ref_mem[key] : 16'h0000;
               if (req_data_i[p].write) begin
                  ref_mem[key] = merge_bytes(old_word, req_data_i[p].wdata, req_data_i[p].be);
               end else begin
                  exp_q[p].push_back(old_word);
               end
            end
         end
         if (!pins_i.cs_n && cmd == sdram_pkg::CMD_WRITE) begin
            dec++;
            if (!dq_oe_i) begin
               $display("dq_oe_o low during a WRITE command");
               note_error();
            end
         end
         if (rd_valid_i) begin
            dec++;
            if (exp_q[rd_port_i].size() == 0) begin
               $display("read return on port %0d with no read outstanding", rd_port_i);
               note_error();
            end else begin
               exp_word = exp_q[rd_port_i].pop_front();
               if (rd_data_i !== exp_word) begin
                  $display("Error %s: expected %h actual %h",
                           test_name(test_id_i), exp_word, rd_data_i);
                  note_error();
               end
            end
            if (test_id_i == 4'd4) begin
               if (int'(rd_port_i) < last_port) begin
                  $display("Error %s: expected port >= %0d actual %0d",
                           test_name(test_id_i), last_port, rd_port_i);
                  note_error();
               end
               last_port = int'(rd_port_i);
            end
         end
         pending_o <= pending_o + inc - dec;

         if (test_id_i == 4'd1) begin
            if (pins_i.cs_n || !pins_i.cke || cmd != sdram_pkg::CMD_NOP || dq_oe_i ||
                rd_valid_i || req_full_i != '0) begin
               $display("outputs not in their reset state after reset");
               note_error();
            end
         end
         if (test_id_i == 4'd5 && req_full_i[0]) begin
            full_seen = 1'b1;
         end

         // refresh spacing over the whole run
         if (!pins_i.cs_n && cmd == sdram_pkg::CMD_AUTO_REFRESH) begin
            refresh_gap = 0;
            if (test_id_i == 4'd6) begin
               refresh_seen++;
            end
         end else begin
            refresh_gap++;
            if (refresh_gap >= REFRESH_LIMIT && !gap_flagged) begin
               $display("no AUTO REFRESH seen within %0d cycles", REFRESH_LIMIT);
               note_error();
               gap_flagged = 1'b1;
            end
         end

         if (test_end_i) begin
            if (test_id_i == 4'd5 && !full_seen) begin
               $display("req_full_o never rose while pushing without pause");
               note_error();
            end
            if (test_id_i == 4'd6 && refresh_seen == 0) begin
               $display("no AUTO REFRESH during the long run");
               note_error();
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
               if (exp_q[p].size() != 0) begin
                  $display("port %0d still waits for %0d reads", p, exp_q[p].size());
                  note_error();
               end
            end
            tests_run++;
            if (test_errs == 0) begin
               tests_ok++;
               $display("test %0d %s: ok", test_id_i, test_name(test_id_i));
            end else begin
               $display("test %0d %s: FAILED with %0d errors",
                        test_id_i, test_name(test_id_i), test_errs);
            end
            test_errs = 0;
            last_port = -1;
            full_seen = 1'b0;
            refresh_seen = 0;
         end
         if (report_i) begin
            $display("summary: %0d tests run, %0d passed, %0d failed, %0d errors",
                     tests_run, tests_ok, tests_run - tests_ok, total_errs);
         end
      end
   end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

   localparam int NUM_PORTS   = 4;
   localparam int MAX_CYCLES  = 4000;

   logic                   sdram_clk;
   logic                   sdram_rst;
   logic [NUM_PORTS-1:0]   req_push;
   sdram_pkg::sdram_req_t  req_data [NUM_PORTS];
   logic [NUM_PORTS-1:0]   req_full;
   sdram_pkg::sdram_pins_t sdram;
   logic [15:0]            dq_o;
   logic                   dq_oe;
   logic [15:0]            dq_i = 16'h0000;
   logic                   rd_valid;
   logic [1:0]             rd_port;
   logic [15:0]            rd_data;
   logic [3:0]             test_id;
   logic                   test_end;
   logic                   report;
   int                     pending;
   int                     errors;
   int                     cycles = 0;
   logic [31:0]            rng = 32'h1b6c_7685;

   // memory model state
   logic [12:0] open_row [4];
   logic [15:0] mem_model [logic [23:0]];
   logic [15:0] rd_stage = 16'h0000;

   tb_clock_gen #(.RESET_CYCLES(3)) u_clock (
      .sdram_clk_o (sdram_clk),
      .sdram_rst_o (sdram_rst)
   );

   sdram_ctrl_top #(
      .NUM_PORTS        (NUM_PORTS),
      .QUEUE_DEPTH      (4),
      .T_RCD            (2),
      .T_RECOVER        (3),
      .T_RFC            (7),
      .REFRESH_INTERVAL (64),
      .CAS_LATENCY      (2)
   ) uut (
      .sdram_clk  (sdram_clk),
      .sdram_rst  (sdram_rst),
      .req_push_i (req_push),
      .req_data_i (req_data),
      .req_full_o (req_full),
      .sdram_o    (sdram),
      .dq_o       (dq_o),
      .dq_oe_o    (dq_oe),
      .dq_i       (dq_i),
      .rd_valid_o (rd_valid),
      .rd_port_o  (rd_port),
      .rd_data_o  (rd_data)
   );

   tb_checker #(.NUM_PORTS(NUM_PORTS), .REFRESH_LIMIT(64 + 2 + 2 + 3 + 7)) u_checker (
      .sdram_clk_i (sdram_clk),
      .sdram_rst_i (sdram_rst),
      .test_id_i   (test_id),
      .test_end_i  (test_end),
      .report_i    (report),
      .req_push_i  (req_push),
      .req_data_i  (req_data),
      .req_full_i  (req_full),
      .pins_i      (sdram),
      .dq_oe_i     (dq_oe),
      .rd_valid_i  (rd_valid),
      .rd_port_i   (rd_port),
      .rd_data_i   (rd_data),
      .pending_o   (pending),
      .errors_o    (errors)
   );

   // SDRAM model latches the row on ACTIVATE and returns data two cycles after READ
   always @(posedge sdram_clk) begin
      logic [2:0]  cmd;
      logic [23:0] key;
      logic [15:0] word;
      cmd  = {sdram.ras_n, sdram.cas_n, sdram.we_n};
      key  = {sdram.ba, open_row[sdram.ba], sdram.addr[8:0]};
      word = mem_model.exists(key) ? mem_model[key] : 16'h0000;
      if (!sdram.cs_n && cmd == sdram_pkg::CMD_ACTIVE) begin
         open_row[sdram.ba] <= sdram.addr;
      end
      if (!sdram.cs_n && cmd == sdram_pkg::CMD_WRITE) begin
         for (int b = 0; b < 2; b++) begin
            if (!sdram.dqm[b]) begin
               word[b*8 +: 8] = dq_o[b*8 +: 8];
            end
         end
         mem_model[key] = word;
      end
      rd_stage <= word;
      dq_i     <= rd_stage;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic next_rand(output logic [31:0] v);
      rng = xorshift32(rng);
      v   = rng;
   endtask

   // port number in the low column bits keeps ports on separate words
   function automatic sdram_pkg::sdram_req_t make_req(input logic        wr,
                                                      input logic [1:0]  port,
                                                      input logic [31:0] r,
                                                      input logic [15:0] data,
                                                      input logic [1:0]  be);
      sdram_pkg::sdram_req_t q;
      q.write = wr;
      q.ba    = r[1:0];
      q.row   = r[14:2];
      q.col   = {r[21:15], port};
      q.wdata = data;
      q.be    = be;
      return q;
   endfunction

   task automatic push_one(input int p, input sdram_pkg::sdram_req_t r);
      req_data[p] <= r;
      req_push[p] <= 1'b1;
      @(posedge sdram_clk);
      req_push[p] <= 1'b0;
   endtask

   // wait for every accepted request to finish and close the test
   task automatic finish_test();
      @(posedge sdram_clk);
      while (pending != 0) begin
         @(posedge sdram_clk);
      end
      repeat (2) @(posedge sdram_clk);
      test_end <= 1'b1;
      @(posedge sdram_clk);
      test_end <= 1'b0;
   endtask

   always @(posedge sdram_clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, requests still outstanding", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      int          p;
      req_push = '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         req_data[i] = '0;
      end
      test_id  = 4'd0;
      test_end = 1'b0;
      report   = 1'b0;
      @(posedge sdram_clk);
      while (sdram_rst) begin
         @(posedge sdram_clk);
      end

      test_id <= 4'd1;
      repeat (6) @(posedge sdram_clk);
      finish_test();

      test_id <= 4'd2;
      for (int i = 0; i < NUM_PORTS; i++) begin
         next_rand(r);
         next_rand(d);
         push_one(i, make_req(1'b1, 2'(i), r, d[15:0], 2'b11));
         push_one(i, make_req(1'b0, 2'(i), r, 16'h0000, 2'b00));
      end
      finish_test();

      test_id <= 4'd3;
      next_rand(r);
      next_rand(d);
      push_one(2, make_req(1'b1, 2'd2, r, d[15:0], 2'b11));
      push_one(2, make_req(1'b1, 2'd2, r, d[31:16], 2'b01));
      push_one(2, make_req(1'b0, 2'd2, r, 16'h0000, 2'b00));
      push_one(2, make_req(1'b1, 2'd2, r, ~d[15:0], 2'b10));
      push_one(2, make_req(1'b0, 2'd2, r, 16'h0000, 2'b00));
      finish_test();

      test_id <= 4'd4;
      next_rand(r);
      push_one(0, make_req(1'b1, 2'd0, r, r[31:16], 2'b11));
      for (int i = 0; i < NUM_PORTS; i++) begin
         next_rand(d);
         req_data[i] <= make_req(1'b0, 2'(i), d, 16'h0000, 2'b00);
      end
      req_push <= '1;
      @(posedge sdram_clk);
      req_push <= '0;
      finish_test();

      // write and read pairs without pause so that some land on a full queue
      test_id <= 4'd5;
      for (int i = 0; i < 8; i++) begin
         next_rand(r);
         next_rand(d);
         push_one(0, make_req(1'b1, 2'd0, r, d[15:0], 2'b11));
         push_one(0, make_req(1'b0, 2'd0, r, 16'h0000, 2'b00));
      end
      finish_test();

      test_id <= 4'd6;
      for (int i = 0; i < 48; i++) begin
         next_rand(r);
         next_rand(d);
         p = int'(d[17:16]);
         push_one(p, make_req(d[20], 2'(p), r, d[15:0],
                              (d[19:18] == 2'b00) ? 2'b11 : d[19:18]));
         repeat (int'(d[23:22])) @(posedge sdram_clk);
      end
      repeat (150) @(posedge sdram_clk);
      finish_test();

      report <= 1'b1;
      @(posedge sdram_clk);
      report <= 1'b0;
      @(posedge sdram_clk);
      if (errors == 0 && uut.u_sequencer.u_assertions.fail_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
hdl/sdram_pkg.sv
hdl/req_queue.sv
hdl/port_arbiter.sv
hdl/sdram_sequencer.sv
hdl/read_capture.sv
hdl/sdram_ctrl_top.sv
testbench/sdram_assertions.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- Makefile
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" sim.log || \
		! grep -q "Simulation passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
